/* src/matmul_pkg.sv */
package matmul_pkg;

  ////////////////////////////////////////
  // tile sizes
  ////////////////////////////////////////

  localparam int DWIDTH = 8;
  localparam int MAT_MUL_SIZE = 4;
  localparam int AWIDTH = 7;
  localparam int MEM_DEPTH = 128;

  // operand reg, product reg, accumulator
  localparam int NUM_CYCLES_IN_MAC = 3;

  ////////////////////////////////////////
  // data types
  ////////////////////////////////////////

  typedef logic signed [DWIDTH-1:0] elem_t;

  // lane 0 in the low bits
  typedef elem_t [MAT_MUL_SIZE-1:0] row_t;

  typedef logic [AWIDTH-1:0] addr_t;

  // one host port request, plain strobes
  typedef struct packed {
    logic  we_a;
    logic  we_b;
    addr_t addr;
    row_t  data;
  } host_req_t;

endpackage

/* src/operand_ram.sv */
module operand_ram #(
  parameter int DEPTH = 128
) (
  input  logic               clk_mem,
  input  matmul_pkg::addr_t  addr,
  input  matmul_pkg::row_t   d,
  input  logic               we,
  output matmul_pkg::row_t   q
);

  matmul_pkg::row_t mem [DEPTH];

  // read-first, q shows the old word on a write
  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= d;
    end
    q <= mem[addr];
  end

endmodule

/* src/operand_skew.sv */
module operand_skew #(
  parameter int LANES = 4
) (
  input  logic              clk_mem,
  input  logic              reset,
  input  logic              skew_clear,
  input  matmul_pkg::row_t  row_in,
  output matmul_pkg::row_t  row_out
);

  // lane i waits i cycles so the operands meet on the diagonal
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign row_out[i] = row_in[i];
    end else begin : g_delay
      matmul_pkg::elem_t dly [i];

      always_ff @(posedge clk_mem) begin
        if (reset || skew_clear) begin
          dly <= '{default: '0};
        end else begin
          dly[0] <= row_in[i];
          for (int s = 1; s < i; s++) begin
            dly[s] <= dly[s-1];
          end
        end
      end

      assign row_out[i] = dly[i-1];
    end
  end

endmodule

/* src/processing_element.sv */
module processing_element (
  input  logic               clk_mem,
  input  logic               reset,
  input  logic               acc_clear,
  input  matmul_pkg::elem_t  in_a,
  input  matmul_pkg::elem_t  in_b,
  output matmul_pkg::elem_t  out_a,
  output matmul_pkg::elem_t  out_b,
  output matmul_pkg::elem_t  out_c
);

  matmul_pkg::elem_t a_q;
  matmul_pkg::elem_t b_q;
  matmul_pkg::elem_t prod_q;
  matmul_pkg::elem_t acc_q;

  logic signed [2*matmul_pkg::DWIDTH-1:0] prod_full;
  matmul_pkg::elem_t                      prod_sat;

  // pass operands on to the right and below
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  ////////////////////////////////////////
  // three stage MAC
  ////////////////////////////////////////

  assign prod_full = (2*matmul_pkg::DWIDTH)'(a_q) * (2*matmul_pkg::DWIDTH)'(b_q);

  // clamp to the element range
  always_comb begin
    if (prod_full > 16'sd127) begin
      prod_sat = 8'sd127;
    end else if (prod_full < -16'sd128) begin
      prod_sat = -8'sd128;
    end else begin
      prod_sat = prod_full[matmul_pkg::DWIDTH-1:0];
    end
  end

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      a_q    <= '0;
      b_q    <= '0;
      prod_q <= '0;
    end else begin
      a_q    <= in_a;
      b_q    <= in_b;
      prod_q <= prod_sat;
    end
  end

  // sum wraps modulo 256
  always_ff @(posedge clk_mem) begin
    if (reset || acc_clear) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_q + prod_q;
    end
  end

  assign out_c = acc_q;

endmodule

/* src/systolic_array.sv */
module systolic_array (
  input  logic              clk_mem,
  input  logic              reset,
  input  logic              acc_clear,
  input  matmul_pkg::row_t  a_skewed,
  input  matmul_pkg::row_t  b_skewed,
  input  logic [3:0]        row_latch,
  input  logic [1:0]        drain_row,
  output matmul_pkg::row_t  drain_data
);

  localparam int N = matmul_pkg::MAT_MUL_SIZE;

  // a moves right along a row, b moves down a column
  matmul_pkg::elem_t a_h [N][N+1];
  matmul_pkg::elem_t b_v [N+1][N];
  matmul_pkg::row_t  pe_res [N];
  matmul_pkg::row_t  row_q [N];

  ////////////////////////////////////////
  // edge feeds
  ////////////////////////////////////////

  for (genvar k = 0; k < N; k++) begin : g_edge
    assign a_h[k][0] = a_skewed[k];
    assign b_v[0][k] = b_skewed[k];
  end

  ////////////////////////////////////////
  // PE grid
  ////////////////////////////////////////

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      processing_element u_pe (
        .clk_mem   (clk_mem),
        .reset     (reset),
        .acc_clear (acc_clear),
        .in_a      (a_h[i][j]),
        .in_b      (b_v[i][j]),
        .out_a     (a_h[i][j+1]),
        .out_b     (b_v[i+1][j]),
        .out_c     (pe_res[i][j])
      );
    end
  end

  ////////////////////////////////////////
  // row capture and drain
  ////////////////////////////////////////

  // row i is complete one cycle after row i-1
  for (genvar r = 0; r < N; r++) begin : g_latch
    always_ff @(posedge clk_mem) begin
      if (row_latch[r]) begin
        row_q[r] <= pe_res[r];
      end
    end
  end

  assign drain_data = row_q[drain_row];

endmodule

/* src/tile_sequencer.sv */
module tile_sequencer (
  input  logic               clk_mem,
  input  logic               reset,
  input  logic               start_mat_mul,
  output matmul_pkg::addr_t  a_addr,
  output matmul_pkg::addr_t  b_addr,
  output logic               skew_clear,
  output logic               acc_clear,
  output logic [3:0]         row_latch,
  output logic [1:0]         drain_row,
  output logic               c_we,
  output matmul_pkg::addr_t  c_addr,
  output logic               done_mat_mul
);

  // row 0 accumulators are final here
  localparam int LATCH_BASE = matmul_pkg::MAT_MUL_SIZE + 6 + matmul_pkg::NUM_CYCLES_IN_MAC;
  localparam int DRAIN_BASE = LATCH_BASE + matmul_pkg::MAT_MUL_SIZE;
  // one count past the last C write when the RAM has taken it
  localparam int DONE_CNT   = DRAIN_BASE + matmul_pkg::MAT_MUL_SIZE;

  logic [4:0]        clk_cnt;
  matmul_pkg::addr_t operand_addr;
  logic [1:0]        drain_idx;
  logic              in_drain;

  ////////////////////////////////////////
  // cycle counter and done
  ////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset || !start_mat_mul) begin
      clk_cnt      <= '0;
      done_mat_mul <= 1'b0;
    end else if (clk_cnt == 5'(DONE_CNT)) begin
      done_mat_mul <= 1'b1;
    end else if (!done_mat_mul) begin
      clk_cnt <= clk_cnt + 5'd1;
    end
  end

  // operand window walks one word per cycle then parks
  always_ff @(posedge clk_mem) begin
    if (reset || !start_mat_mul) begin
      operand_addr <= matmul_pkg::addr_t'(matmul_pkg::MEM_DEPTH - 1);
    end else if (clk_cnt < 5'(matmul_pkg::MAT_MUL_SIZE)) begin
      operand_addr <= matmul_pkg::addr_t'(clk_cnt);
    end else begin
      operand_addr <= matmul_pkg::addr_t'(matmul_pkg::MEM_DEPTH - 1);
    end
  end

  // A holds columns and B holds rows so both walk together
  assign a_addr = operand_addr;
  assign b_addr = operand_addr;

  assign skew_clear = (clk_cnt == '0);
  assign acc_clear  = !start_mat_mul;

  ////////////////////////////////////////
  // row latch and C write-back
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      row_latch[i] = (clk_cnt == 5'(LATCH_BASE + i));
    end
  end

  assign drain_idx = 2'(clk_cnt - 5'(DRAIN_BASE));
  assign in_drain  = (clk_cnt >= 5'(DRAIN_BASE)) && (clk_cnt < 5'(DONE_CNT));

  assign c_we      = in_drain;
  assign drain_row = drain_idx;
  assign c_addr    = matmul_pkg::addr_t'(drain_idx);

endmodule

/* src/matmul_mem_bank.sv */
module matmul_mem_bank (
  input  logic                   clk_mem,
  input  logic                   reset,
  input  matmul_pkg::host_req_t  host,
  input  logic                   enable_writing_to_mem,
  input  logic                   enable_reading_from_mem,
  input  matmul_pkg::addr_t      a_addr,
  input  matmul_pkg::addr_t      b_addr,
  input  matmul_pkg::addr_t      c_addr,
  input  logic                   c_we,
  input  matmul_pkg::row_t       c_data,
  output matmul_pkg::row_t       a_row,
  output matmul_pkg::row_t       b_row,
  output matmul_pkg::row_t       data_from_out_mat
);

  matmul_pkg::host_req_t host_q;
  logic                  en_wr_q;
  logic                  en_rd_q;

  matmul_pkg::addr_t a_addr_mux_q;
  matmul_pkg::addr_t b_addr_mux_q;
  matmul_pkg::addr_t c_addr_mux_q;
  logic              we_a_q;
  logic              we_b_q;
  logic              c_we_q;
  matmul_pkg::row_t  wdata_q;
  matmul_pkg::row_t  c_data_q;

  // operand valid follows the sequencer address down the pipe
  logic a_valid_q;
  logic b_valid_q;
  logic a_valid_q2;
  logic b_valid_q2;

  matmul_pkg::row_t a_q;
  matmul_pkg::row_t b_q;
  matmul_pkg::row_t c_q;

  ////////////////////////////////////////
  // host port registers
  ////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      host_q  <= '0;
      en_wr_q <= 1'b0;
      en_rd_q <= 1'b0;
    end else begin
      host_q  <= host;
      en_wr_q <= enable_writing_to_mem;
      en_rd_q <= enable_reading_from_mem;
    end
  end

  ////////////////////////////////////////
  // address muxing
  ////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      a_addr_mux_q <= '0;
      b_addr_mux_q <= '0;
      c_addr_mux_q <= '0;
      we_a_q       <= 1'b0;
      we_b_q       <= 1'b0;
      c_we_q       <= 1'b0;
      a_valid_q    <= 1'b0;
      b_valid_q    <= 1'b0;
      a_valid_q2   <= 1'b0;
      b_valid_q2   <= 1'b0;
    end else begin
      a_addr_mux_q <= en_wr_q ? host_q.addr : a_addr;
      b_addr_mux_q <= en_wr_q ? host_q.addr : b_addr;
      c_addr_mux_q <= en_rd_q ? host_q.addr : c_addr;
      we_a_q       <= host_q.we_a && en_wr_q;
      we_b_q       <= host_q.we_b && en_wr_q;
      c_we_q       <= c_we;
      // words past the operand window feed zeros
      a_valid_q    <= !en_wr_q &&
                      (a_addr < matmul_pkg::addr_t'(matmul_pkg::MAT_MUL_SIZE));
      b_valid_q    <= !en_wr_q &&
                      (b_addr < matmul_pkg::addr_t'(matmul_pkg::MAT_MUL_SIZE));
      a_valid_q2   <= a_valid_q;
      b_valid_q2   <= b_valid_q;
    end
  end

  // write data lines up with the muxed address
  always_ff @(posedge clk_mem) begin
    wdata_q  <= host_q.data;
    c_data_q <= c_data;
  end

  ////////////////////////////////////////
  // memories
  ////////////////////////////////////////

  operand_ram #(.DEPTH(matmul_pkg::MEM_DEPTH)) u_ram_a (
    .clk_mem (clk_mem),
    .addr    (a_addr_mux_q),
    .d       (wdata_q),
    .we      (we_a_q),
    .q       (a_q)
  );

  operand_ram #(.DEPTH(matmul_pkg::MEM_DEPTH)) u_ram_b (
    .clk_mem (clk_mem),
    .addr    (b_addr_mux_q),
    .d       (wdata_q),
    .we      (we_b_q),
    .q       (b_q)
  );

  // one result row per word
  operand_ram #(.DEPTH(matmul_pkg::MEM_DEPTH)) u_ram_c (
    .clk_mem (clk_mem),
    .addr    (c_addr_mux_q),
    .d       (c_data_q),
    .we      (c_we_q),
    .q       (c_q)
  );

  ////////////////////////////////////////
  // read word registers
  ////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      a_row             <= '0;
      b_row             <= '0;
      data_from_out_mat <= '0;
    end else begin
      a_row             <= a_valid_q2 ? a_q : '0;
      b_row             <= b_valid_q2 ? b_q : '0;
      data_from_out_mat <= c_q;
    end
  end

endmodule

/* src/matmul_tile_top.sv */
module matmul_tile_top (
  input  logic                   clk_mem,
  input  logic                   reset,
  input  matmul_pkg::host_req_t  host,
  input  logic                   enable_writing_to_mem,
  input  logic                   enable_reading_from_mem,
  input  logic                   start_mat_mul,
  output logic                   done_mat_mul,
  output matmul_pkg::row_t       data_from_out_mat
);

  matmul_pkg::addr_t a_addr;
  matmul_pkg::addr_t b_addr;
  matmul_pkg::addr_t c_addr;
  logic              c_we;
  logic              skew_clear;
  logic              acc_clear;
  logic [3:0]        row_latch;
  logic [1:0]        drain_row;

  matmul_pkg::row_t a_row;
  matmul_pkg::row_t b_row;
  matmul_pkg::row_t a_skewed;
  matmul_pkg::row_t b_skewed;
  matmul_pkg::row_t drain_data;

  matmul_mem_bank u_mem_bank (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .host                    (host),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .a_addr                  (a_addr),
    .b_addr                  (b_addr),
    .c_addr                  (c_addr),
    .c_we                    (c_we),
    .c_data                  (drain_data),
    .a_row                   (a_row),
    .b_row                   (b_row),
    .data_from_out_mat       (data_from_out_mat)
  );

  tile_sequencer u_sequencer (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .skew_clear    (skew_clear),
    .acc_clear     (acc_clear),
    .row_latch     (row_latch),
    .drain_row     (drain_row),
    .c_we          (c_we),
    .c_addr        (c_addr),
    .done_mat_mul  (done_mat_mul)
  );

  ////////////////////////////////////////
  // diagonal skew of both operands
  ////////////////////////////////////////

  operand_skew #(.LANES(matmul_pkg::MAT_MUL_SIZE)) u_skew_a (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .skew_clear (skew_clear),
    .row_in     (a_row),
    .row_out    (a_skewed)
  );

  operand_skew #(.LANES(matmul_pkg::MAT_MUL_SIZE)) u_skew_b (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .skew_clear (skew_clear),
    .row_in     (b_row),
    .row_out    (b_skewed)
  );

  systolic_array u_array (
    .clk_mem    (clk_mem),
    .reset      (reset),
    .acc_clear  (acc_clear),
    .a_skewed   (a_skewed),
    .b_skewed   (b_skewed),
    .row_latch  (row_latch),
    .drain_row  (drain_row),
    .drain_data (drain_data)
  );

endmodule

/* testbench/matmul_tile_asserts.sv */
module matmul_tile_asserts (
  input logic clk_mem,
  input logic reset,
  input logic start_mat_mul,
  input logic done_mat_mul,
  input logic c_we
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////
  // done protocol
  ////////////////////////////////////////

  // done only rises out of a running multiply
  no_rise_when_idle: assert property (@(posedge clk_mem) disable iff (reset)
    $rose(done_mat_mul) |-> $past(start_mat_mul))
    else $error("done_mat_mul rose while start_mat_mul was low");

  done_holds: assert property (@(posedge clk_mem) disable iff (reset)
    done_mat_mul && start_mat_mul |=> done_mat_mul)
    else $error("done_mat_mul dropped while start_mat_mul stayed high");

  // one edge after start is seen low
  done_falls: assert property (@(posedge clk_mem) disable iff (reset)
    !start_mat_mul |=> !done_mat_mul)
    else $error("done_mat_mul still high one edge after start_mat_mul went low");

  ////////////////////////////////////////
  // C write-back window
  ////////////////////////////////////////

  c_write_in_run: assert property (@(posedge clk_mem) disable iff (reset)
    c_we |-> start_mat_mul && !done_mat_mul)
    else $error("c_we outside of a running multiply");

endmodule

bind matmul_tile_top matmul_tile_asserts u_asserts (
  .clk_mem       (clk_mem),
  .reset         (reset),
  .start_mat_mul (start_mat_mul),
  .done_mat_mul  (done_mat_mul),
  .c_we          (c_we)
);

/* testbench/tb_matmul_tile.sv */
module tb_matmul_tile;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N            = matmul_pkg::MAT_MUL_SIZE;
  localparam int NUM_CASES    = 7;
  localparam int DONE_TIMEOUT = 100;

  localparam int MODE_DIRECT = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_KEEP_A = 2;

  typedef matmul_pkg::elem_t [N-1:0][N-1:0] mat_t;

  logic                  clk_mem = 1'b0;
  logic                  reset;
  matmul_pkg::host_req_t host;
  logic                  enable_writing_to_mem;
  logic                  enable_reading_from_mem;
  logic                  start_mat_mul;
  logic                  done_mat_mul;
  matmul_pkg::row_t      data_from_out_mat;

  ////////////////////////////////////////
  // case table
  ////////////////////////////////////////

  // identity, small positive, mixed sign, saturating, new B only, two random
  int mode_tbl [NUM_CASES] = '{
    MODE_DIRECT, MODE_DIRECT, MODE_DIRECT, MODE_DIRECT,
    MODE_KEEP_A, MODE_RANDOM, MODE_RANDOM
  };
  int lo_tbl   [NUM_CASES] = '{0, 0, 0, 0, 0, -128, -8};
  int hi_tbl   [NUM_CASES] = '{0, 0, 0, 0, 0, 127, 7};

  // inner group is one matrix row
  int a_tbl [NUM_CASES][N][N] = '{
    '{'{1, 0, 0, 0}, '{0, 1, 0, 0}, '{0, 0, 1, 0}, '{0, 0, 0, 1}},
    '{'{1, 2, 1, 0}, '{0, 3, 1, 2}, '{2, 0, 1, 1}, '{1, 1, 1, 1}},
    '{'{-3, 2, -1, 4}, '{5, -6, 7, -8}, '{-2, -2, 3, 3}, '{1, -1, 1, -1}},
    '{'{100, 100, 100, 100}, '{-128, -128, -128, -128},
      '{127, -128, 100, -100}, '{12, 11, -12, -11}},
    '{default: 0},
    '{default: 0},
    '{default: 0}
  };

  int b_tbl [NUM_CASES][N][N] = '{
    '{'{1, 2, 3, 4}, '{5, 6, 7, 8}, '{9, 10, 11, 12}, '{13, 14, 15, 16}},
    '{'{2, 1, 0, 1}, '{1, 0, 2, 1}, '{0, 1, 1, 2}, '{1, 2, 1, 0}},
    '{'{4, -3, 2, -1}, '{-1, 2, -3, 4}, '{6, -5, 4, -3}, '{-2, 1, 0, 7}},
    '{'{100, 127, -128, 1}, '{100, 127, -128, 1},
      '{100, 127, -128, 1}, '{100, 127, -128, 1}},
    '{'{1, -1, 2, -2}, '{3, -3, 4, -4}, '{5, -5, 6, -6}, '{7, -7, 8, -8}},
    '{default: 0},
    '{default: 0}
  };

  // words outside the operand window get noise each case
  int junk_addr [4] = '{4, 5, 64, 127};

  mat_t a_mat   [NUM_CASES];
  mat_t b_mat   [NUM_CASES];
  mat_t exp_tbl [NUM_CASES];

  matmul_tile_top u_matmul_tile_top (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .host                    (host),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .start_mat_mul           (start_mat_mul),
    .done_mat_mul            (done_mat_mul),
    .data_from_out_mat       (data_from_out_mat)
  );

  always #5 clk_mem = ~clk_mem;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // saturate each product and wrap the 8 bit sum
  function automatic mat_t model_mul(mat_t a, mat_t b);
    mat_t              c;
    int                prod;
    matmul_pkg::elem_t acc;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        acc = '0;
        for (int k = 0; k < N; k++) begin
          prod = int'($signed(a[i][k])) * int'($signed(b[k][j]));
          if (prod > 127) begin
            prod = 127;
          end else if (prod < -128) begin
            prod = -128;
          end
          acc = matmul_pkg::elem_t'(int'($signed(acc)) + prod);
        end
        c[i][j] = acc;
      end
    end
    return c;
  endfunction

  function automatic matmul_pkg::elem_t rand_elem(int lo, int hi);
    return matmul_pkg::elem_t'(lo + int'($urandom % (hi - lo + 1)));
  endfunction

  task automatic prepare_table();
    for (int c = 0; c < NUM_CASES; c++) begin
      for (int i = 0; i < N; i++) begin
        for (int k = 0; k < N; k++) begin
          if (mode_tbl[c] == MODE_RANDOM) begin
            a_mat[c][i][k] = rand_elem(lo_tbl[c], hi_tbl[c]);
            b_mat[c][i][k] = rand_elem(lo_tbl[c], hi_tbl[c]);
          end else if (mode_tbl[c] == MODE_KEEP_A) begin
            a_mat[c][i][k] = a_mat[c-1][i][k];
            b_mat[c][i][k] = matmul_pkg::elem_t'(b_tbl[c][i][k]);
          end else begin
            a_mat[c][i][k] = matmul_pkg::elem_t'(a_tbl[c][i][k]);
            b_mat[c][i][k] = matmul_pkg::elem_t'(b_tbl[c][i][k]);
          end
        end
      end
      exp_tbl[c] = model_mul(a_mat[c], b_mat[c]);
    end
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_row(string name, matmul_pkg::row_t exp, matmul_pkg::row_t act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // host port
  ////////////////////////////////////////

  task automatic write_word(logic to_a, matmul_pkg::addr_t addr, matmul_pkg::row_t data);
    @(negedge clk_mem);
    enable_writing_to_mem = 1'b1;
    host.we_a             = to_a;
    host.we_b             = !to_a;
    host.addr             = addr;
    host.data             = data;
  endtask

  // A goes in as columns and B as rows
  task automatic load_operands(mat_t a, mat_t b, logic load_a);
    matmul_pkg::row_t col;
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < N; i++) begin
        col[i] = a[i][k];
      end
      if (load_a) begin
        write_word(1'b1, matmul_pkg::addr_t'(k), col);
      end
      write_word(1'b0, matmul_pkg::addr_t'(k), b[k]);
    end
    for (int n = 0; n < 4; n++) begin
      write_word(1'b1, matmul_pkg::addr_t'(junk_addr[n]), matmul_pkg::row_t'($urandom));
      write_word(1'b0, matmul_pkg::addr_t'(junk_addr[n]), matmul_pkg::row_t'($urandom));
    end
    @(negedge clk_mem);
    enable_writing_to_mem = 1'b0;
    host                  = '0;
    // let the last write land
    repeat (3) @(negedge clk_mem);
  endtask

  task automatic run_matmul();
    int cycles;
    cycles = 0;
    @(negedge clk_mem);
    start_mat_mul = 1'b1;
    while (done_mat_mul !== 1'b1 && cycles < DONE_TIMEOUT) begin
      @(negedge clk_mem);
      cycles++;
    end
    if (done_mat_mul !== 1'b1) begin
      $display("No done_mat_mul within %0d cycles of start_mat_mul.", DONE_TIMEOUT);
      abort_run();
    end
    @(negedge clk_mem);
    check_bit("done_mat_mul", 1'b1, done_mat_mul);
    start_mat_mul = 1'b0;
    @(negedge clk_mem);
    check_bit("done_mat_mul", 1'b0, done_mat_mul);
  endtask

  // word shows three edges after the address is taken
  task automatic read_c_row(matmul_pkg::addr_t addr, output matmul_pkg::row_t row);
    @(negedge clk_mem);
    enable_reading_from_mem = 1'b1;
    host                    = '0;
    host.addr               = addr;
    repeat (4) @(negedge clk_mem);
    row = data_from_out_mat;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    matmul_pkg::row_t got;
    void'($urandom(32'h8947));
    reset                   = 1'b1;
    host                    = '0;
    enable_writing_to_mem   = 1'b0;
    enable_reading_from_mem = 1'b0;
    start_mat_mul           = 1'b0;
    prepare_table();
    repeat (4) @(negedge clk_mem);
    check_bit("done_mat_mul", 1'b0, done_mat_mul);
    check_row("data_from_out_mat", '0, data_from_out_mat);
    reset = 1'b0;

    for (int c = 0; c < NUM_CASES; c++) begin
      load_operands(a_mat[c], b_mat[c], mode_tbl[c] != MODE_KEEP_A);
      run_matmul();
      for (int r = 0; r < N; r++) begin
        read_c_row(matmul_pkg::addr_t'(r), got);
        check_row($sformatf("data_from_out_mat case %0d row %0d", c, r), exp_tbl[c][r], got);
      end
      @(negedge clk_mem);
      enable_reading_from_mem = 1'b0;
      host                    = '0;
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* list.f */
src/matmul_pkg.sv
src/operand_ram.sv
src/operand_skew.sv
src/processing_element.sv
src/systolic_array.sv
src/tile_sequencer.sv
src/matmul_mem_bank.sv
src/matmul_tile_top.sv
testbench/matmul_tile_asserts.sv
testbench/tb_matmul_tile.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_matmul_tile
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# build the simulation binary from the file list
compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# exit status of the binary is the test result
run: compile
	$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
